/* Makefile */
SIM := obj_dir/Vexe_stage_tb

.PHONY: all run clean

all: $(SIM)

$(SIM): all.f $(wildcard logic/*.sv) $(wildcard dv/*.sv) $(wildcard include/*.svh)
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module exe_stage_tb -f all.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
+incdir+include
logic/exe_cfg_pkg.sv
logic/exe_ops_pkg.sv
logic/operand_select.sv
logic/compare_unit.sv
logic/int_alu.sv
logic/mul_unit.sv
logic/exe_result_reg.sv
logic/exe_stage.sv
dv/exe_stage_tb.sv

/* include/exe_ref_model.svh */
// Behavioral model of the RV32 execute stage used to predict registered outputs
`ifndef EXE_REF_MODEL_SVH
`define EXE_REF_MODEL_SVH

// Enum types come from exe_ops_pkg in the including scope
function automatic void exe_ref_model(
   input  alu_op_e       alu_op,
   input  mul_op_e       mul_op,
   input  br_op_e        br_op,
   input  opr1_sel_e     opr1_sel,
   input  opr2_sel_e     opr2_sel,
   input  cmp_opr2_sel_e cmp_opr2_sel,
   input  logic          jump_req,
   input  logic          branch_req,
   input  logic [31:0]   pc,
   input  logic [31:0]   imm,
   input  logic [31:0]   rs1_data,
   input  logic [31:0]   rs2_data,
   input  logic [3:0]    fwd,
   input  logic [31:0]   lsu_data,
   input  logic [31:0]   wrb_data,
   output logic [31:0]   result,
   output logic [31:0]   store_data,
   output logic          new_pc_req,
   output logic [31:0]   pc_new
);
   logic [31:0] rs1;
   logic [31:0] rs2;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] c;
   logic [31:0] alu;
   logic [63:0] prod;
   logic        taken;

   // fwd holds {lsu_rs1, wrb_rs1, lsu_rs2, wrb_rs2}
   rs1 = fwd[3] ? lsu_data : (fwd[2] ? wrb_data : rs1_data);
   rs2 = fwd[1] ? lsu_data : (fwd[0] ? wrb_data : rs2_data);
   a   = (opr1_sel == OPR1_PC) ? pc : rs1;
   b   = (opr2_sel == OPR2_IMM) ? imm : rs2;
   c   = (cmp_opr2_sel == CMP_OPR2_IMM) ? imm : rs2;

   case (alu_op)
      ALU_AND:       alu = a & b;
      ALU_OR:        alu = a | b;
      ALU_XOR:       alu = a ^ b;
      ALU_ADD:       alu = a + b;
      ALU_SUB:       alu = a - b;
      ALU_SLL:       alu = a << b[4:0];
      ALU_SRL:       alu = a >> b[4:0];
      ALU_SRA:       alu = $unsigned($signed(a) >>> b[4:0]);
      ALU_COPY_OPR1: alu = a;
      ALU_COPY_OPR2: alu = b;
      ALU_SLT:       alu = {31'b0, $signed(rs1) < $signed(c)};
      ALU_SLTU:      alu = {31'b0, rs1 < c};
      default:       alu = '0;
   endcase

   // 64-bit products of explicitly extended operands
   case (mul_op)
      MULH:    prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
      MULHSU:  prod = {{32{a[31]}}, a} * {32'b0, b};
      default: prod = {32'b0, a} * {32'b0, b};
   endcase

   case (br_op)
      BR_EQ:   taken = (rs1 == c);
      BR_NE:   taken = (rs1 != c);
      BR_LT:   taken = ($signed(rs1) < $signed(c));
      BR_GE:   taken = ($signed(rs1) >= $signed(c));
      BR_LTU:  taken = (rs1 < c);
      BR_GEU:  taken = (rs1 >= c);
      default: taken = 1'b0;
   endcase

   if (mul_op == MUL_NONE) begin
      result = alu;
   end else begin
      result = (mul_op == MUL) ? prod[31:0] : prod[63:32];
   end
   store_data = rs2;
   new_pc_req = jump_req | (branch_req & taken);
   pc_new     = {alu[31:2], 2'b00};
endfunction

`endif

/* dv/exe_stage_tb.sv */
// Execute stage testbench with a reference model, a compare process and a watchdog
`timescale 1ns/1ns

module exe_stage_tb import exe_cfg_pkg::*, exe_ops_pkg::*; ();

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 3;
   localparam int N_IDLE       = 4;
   localparam int N_ALU        = 240;
   localparam int N_FWD        = 120;
   localparam int N_BR         = 160;
   localparam int N_CORNER     = 4 * 5 * 5;
   localparam int N_MUL        = 100;
   localparam int N_STREAM     = 240;
   localparam int TOTAL_CYCLES = N_IDLE + N_ALU + N_FWD + N_BR + N_CORNER + N_MUL + N_STREAM;
   // Reset, pipeline drain and some slack on top of the stimulus length
   localparam int WATCHDOG_NS  = (TOTAL_CYCLES + RESET_CYCLES + 50) * CLK_PERIOD;

   logic                         clk;
   logic                         reset_i;
   logic                         valid_i;
   alu_op_e                      alu_op_i;
   mul_op_e                      mul_op_i;
   br_op_e                       br_op_i;
   opr1_sel_e                    opr1_sel_i;
   opr2_sel_e                    opr2_sel_i;
   cmp_opr2_sel_e                cmp_opr2_sel_i;
   logic                         jump_req_i;
   logic                         branch_req_i;
   logic                         rd_wr_req_i;
   logic [RF_AWIDTH_DEFAULT-1:0] rd_addr_i;
   logic [31:0]                  pc_i;
   logic [31:0]                  imm_i;
   logic [31:0]                  rs1_data_i;
   logic [31:0]                  rs2_data_i;
   logic                         fwd_lsu_rs1_i;
   logic                         fwd_wrb_rs1_i;
   logic                         fwd_lsu_rs2_i;
   logic                         fwd_wrb_rs2_i;
   logic [31:0]                  lsu_fb_data_i;
   logic [31:0]                  wrb_fb_data_i;
   logic                         valid_o;
   logic                         rd_wr_req_o;
   logic                         new_pc_req_o;
   logic [31:0]                  result_o;
   logic [31:0]                  store_data_o;
   logic [31:0]                  pc_new_o;
   logic [RF_AWIDTH_DEFAULT-1:0] rd_addr_o;

   // Expected outputs with one entry per issued cycle
   string                        q_name[$];
   logic                         q_valid[$];
   logic                         q_rd_wr[$];
   logic                         q_npc[$];
   logic [31:0]                  q_result[$];
   logic [31:0]                  q_store[$];
   logic [31:0]                  q_pc_new[$];
   logic [RF_AWIDTH_DEFAULT-1:0] q_rd_addr[$];

   `include "exe_ref_model.svh"

   exe_stage UUT (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////
   // Stimulus helpers
   ////////////////////

   // Plain random ALU instruction without forwarding, branch or multiply
   task automatic randomize_inputs();
      valid_i        = 1'b1;
      alu_op_i       = alu_op_e'($urandom_range(0, 11));
      mul_op_i       = MUL_NONE;
      br_op_i        = BR_NONE;
      opr1_sel_i     = opr1_sel_e'($urandom_range(0, 1));
      opr2_sel_i     = opr2_sel_e'($urandom_range(0, 1));
      cmp_opr2_sel_i = cmp_opr2_sel_e'($urandom_range(0, 1));
      jump_req_i     = 1'b0;
      branch_req_i   = 1'b0;
      rd_wr_req_i    = 1'($urandom_range(0, 1));
      rd_addr_i      = RF_AWIDTH_DEFAULT'($urandom());
      pc_i           = $urandom();
      imm_i          = $urandom();
      rs1_data_i     = $urandom();
      rs2_data_i     = $urandom();
      lsu_fb_data_i  = $urandom();
      wrb_fb_data_i  = $urandom();
      {fwd_lsu_rs1_i, fwd_wrb_rs1_i, fwd_lsu_rs2_i, fwd_wrb_rs2_i} = 4'b0000;
   endtask

   task automatic push_expect(input string name);
      logic [31:0] e_result;
      logic [31:0] e_store;
      logic [31:0] e_pc_new;
      logic        e_npc;
      exe_ref_model(alu_op_i, mul_op_i, br_op_i, opr1_sel_i, opr2_sel_i, cmp_opr2_sel_i,
                    jump_req_i, branch_req_i, pc_i, imm_i, rs1_data_i, rs2_data_i,
                    {fwd_lsu_rs1_i, fwd_wrb_rs1_i, fwd_lsu_rs2_i, fwd_wrb_rs2_i},
                    lsu_fb_data_i, wrb_fb_data_i, e_result, e_store, e_npc, e_pc_new);
      q_name.push_back(name);
      q_valid.push_back(valid_i);
      q_rd_wr.push_back(valid_i & rd_wr_req_i);
      q_npc.push_back(valid_i & e_npc);
      q_result.push_back(e_result);
      q_store.push_back(e_store);
      q_pc_new.push_back(e_pc_new);
      q_rd_addr.push_back(rd_addr_i);
   endtask

   function automatic logic [31:0] corner_value(input int idx);
      case (idx)
         0:       return 32'h0000_0000;
         1:       return 32'hffff_ffff;
         2:       return 32'h8000_0000;
         3:       return 32'h7fff_ffff;
         default: return 32'h0000_0001;
      endcase
   endfunction

   // One instruction per falling edge with overrides picked by the phase name
   task automatic run_phase(input string name, input int count);
      for (int n = 0; n < count; n++) begin
         @(negedge clk);
         randomize_inputs();
         case (name)
            "reset_idle": begin
               // Strobes set high to show that an idle cycle masks them
               valid_i     = 1'b0;
               jump_req_i  = 1'b1;
               rd_wr_req_i = 1'b1;
            end
            "forwarding": begin
               {fwd_lsu_rs1_i, fwd_wrb_rs1_i, fwd_lsu_rs2_i, fwd_wrb_rs2_i} =
                  4'($urandom_range(0, 15));
               opr1_sel_i = OPR1_REG;
               opr2_sel_i = OPR2_REG;
               alu_op_i   = alu_op_e'($urandom_range(0, 4));
            end
            "branch_jump": begin
               alu_op_i   = ALU_ADD;
               opr2_sel_i = OPR2_IMM;
               if ($urandom_range(0, 7) == 0) begin
                  jump_req_i = 1'b1;
               end else begin
                  br_op_i      = br_op_e'($urandom_range(1, 6));
                  branch_req_i = 1'b1;
               end
               // Equal operands hit the EQ, GE and GEU edges
               if ($urandom_range(0, 3) == 0) begin
                  rs2_data_i = rs1_data_i;
                  imm_i      = rs1_data_i;
               end
            end
            "mul_random": begin
               mul_op_i = mul_op_e'($urandom_range(1, 4));
            end
            "stream_gaps": begin
               valid_i = ($urandom_range(0, 9) < 7);
               {fwd_lsu_rs1_i, fwd_wrb_rs1_i, fwd_lsu_rs2_i, fwd_wrb_rs2_i} =
                  4'($urandom_range(0, 15));
               br_op_i      = br_op_e'($urandom_range(0, 6));
               branch_req_i = 1'($urandom_range(0, 1));
               jump_req_i   = ($urandom_range(0, 7) == 0);
               if ($urandom_range(0, 3) == 0) begin
                  mul_op_i = mul_op_e'($urandom_range(1, 4));
               end
            end
            default: begin
            end
         endcase
         push_expect(name);
      end
   endtask

   task automatic multiply_corners();
      for (int op = 1; op <= 4; op++) begin
         for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
               @(negedge clk);
               randomize_inputs();
               mul_op_i   = mul_op_e'(op);
               opr1_sel_i = OPR1_REG;
               opr2_sel_i = OPR2_REG;
               rs1_data_i = corner_value(i);
               rs2_data_i = corner_value(j);
               push_expect("mul_corner");
            end
         end
      end
   endtask

   ////////////////////
   // Checking
   ////////////////////

   task automatic compare_field(input string test, input string field,
                                input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("ERR %s: %s expected %h actual %h", test, field, exp, act);
         $display("SIMULATION FAILED");
         $fatal(1, "Output mismatch, run stopped");
      end
   endtask

   // Sample 1 ns after the rising edge when the register outputs have settled
   initial begin
      string                        tname;
      logic                         exp_valid;
      logic                         exp_rd_wr;
      logic                         exp_npc;
      logic [31:0]                  held_result;
      logic [31:0]                  held_store;
      logic [31:0]                  held_pc_new;
      logic [RF_AWIDTH_DEFAULT-1:0] held_rd_addr;
      held_result  = '0;
      held_store   = '0;
      held_pc_new  = '0;
      held_rd_addr = '0;
      forever begin
         @(posedge clk);
         #1;
         if (q_valid.size() > 0) begin
            tname     = q_name.pop_front();
            exp_valid = q_valid.pop_front();
            exp_rd_wr = q_rd_wr.pop_front();
            exp_npc   = q_npc.pop_front();
            // Data outputs keep the last valid payload across idle cycles
            if (exp_valid) begin
               held_result  = q_result[0];
               held_store   = q_store[0];
               held_pc_new  = q_pc_new[0];
               held_rd_addr = q_rd_addr[0];
            end
            void'(q_result.pop_front());
            void'(q_store.pop_front());
            void'(q_pc_new.pop_front());
            void'(q_rd_addr.pop_front());
            compare_field(tname, "valid_o", 32'(exp_valid), 32'(valid_o));
            compare_field(tname, "rd_wr_req_o", 32'(exp_rd_wr), 32'(rd_wr_req_o));
            compare_field(tname, "new_pc_req_o", 32'(exp_npc), 32'(new_pc_req_o));
            compare_field(tname, "result_o", held_result, result_o);
            compare_field(tname, "store_data_o", held_store, store_data_o);
            compare_field(tname, "pc_new_o", held_pc_new, pc_new_o);
            compare_field(tname, "rd_addr_o", 32'(held_rd_addr), 32'(rd_addr_o));
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the stimulus did not finish within %0d ns", WATCHDOG_NS);
      $display("SIMULATION FAILED");
      $fatal(1, "Watchdog expired");
   end

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      void'($urandom(32'he5a0));
      reset_i = 1'b1;
      randomize_inputs();
      valid_i = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset_i = 1'b0;
      run_phase("reset_idle", N_IDLE);
      run_phase("alu_random", N_ALU);
      run_phase("forwarding", N_FWD);
      run_phase("branch_jump", N_BR);
      multiply_corners();
      run_phase("mul_random", N_MUL);
      run_phase("stream_gaps", N_STREAM);
      wait (q_valid.size() == 0);
      @(negedge clk);
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule : exe_stage_tb

/* logic/compare_unit.sv */
// Comparison subtractor producing less-than flags and the branch decision
`timescale 1ns/1ns

module compare_unit import exe_ops_pkg::*; #(
   parameter int XLEN
) (
   input  logic [XLEN-1:0] rs1_val_i,
   input  logic [XLEN-1:0] rs2_val_i,
   input  logic [XLEN-1:0] imm_i,
   input  cmp_opr2_sel_e   cmp_opr2_sel_i,
   input  br_op_e          br_op_i,
   output logic            lt_o,
   output logic            ltu_o,
   output logic            branch_taken_o
);

   logic [XLEN-1:0] cmp_opr2;
   logic [XLEN:0]   cmp_diff;
   logic            cmp_zero;
   logic            cmp_neg;
   logic            cmp_ovf;

   // SLTI and SLTIU compare against the immediate
   assign cmp_opr2 = (cmp_opr2_sel_i == CMP_OPR2_IMM) ? imm_i : rs2_val_i;

   // Extra top bit catches the borrow of the unsigned subtraction
   assign cmp_diff = {1'b0, rs1_val_i} - {1'b0, cmp_opr2};

   assign cmp_zero = ~|cmp_diff[XLEN-1:0];
   assign cmp_neg  = cmp_diff[XLEN-1];
   assign cmp_ovf  = (rs1_val_i[XLEN-1] ^ cmp_opr2[XLEN-1]) & (rs1_val_i[XLEN-1] ^ cmp_neg);

   assign lt_o  = cmp_neg ^ cmp_ovf;
   assign ltu_o = cmp_diff[XLEN];

   always_comb begin
      case (br_op_i)
         BR_EQ:   branch_taken_o = cmp_zero;
         BR_NE:   branch_taken_o = ~cmp_zero;
         BR_LT:   branch_taken_o = lt_o;
         BR_GE:   branch_taken_o = ~lt_o;
         BR_LTU:  branch_taken_o = ltu_o;
         BR_GEU:  branch_taken_o = ~ltu_o;
         default: branch_taken_o = 1'b0;
      endcase
   end

endmodule : compare_unit

/* logic/exe_cfg_pkg.sv */
// Execute stage configuration with default data path and register address widths
package exe_cfg_pkg;

   ////////////////////
   // Data path
   ////////////////////

   // Integer register width
   localparam int XLEN_DEFAULT = 32;

   ////////////////////
   // Register file
   ////////////////////

   // Five bits address the 32 integer registers
   localparam int RF_AWIDTH_DEFAULT = 5;

endpackage : exe_cfg_pkg

/* logic/exe_ops_pkg.sv */
// Execute stage operation codes and operand selector encodings
package exe_ops_pkg;

   // Base integer ALU operations
   typedef enum logic [3:0] {
      ALU_AND       = 4'd0,
      ALU_OR        = 4'd1,
      ALU_XOR       = 4'd2,
      ALU_ADD       = 4'd3,
      ALU_SUB       = 4'd4,
      ALU_SLL       = 4'd5,
      ALU_SRL       = 4'd6,
      ALU_SRA       = 4'd7,
      ALU_COPY_OPR1 = 4'd8,
      ALU_COPY_OPR2 = 4'd9,
      ALU_SLT       = 4'd10,
      ALU_SLTU      = 4'd11
   } alu_op_e;

   // M extension multiply group
   // MUL_NONE selects the ALU result
   typedef enum logic [2:0] {
      MUL_NONE   = 3'd0,
      MUL        = 3'd1,
      MULH       = 3'd2,
      MULHSU     = 3'd3,
      MULHU      = 3'd4
   } mul_op_e;

   // Conditional branch comparisons
   typedef enum logic [2:0] {
      BR_NONE    = 3'd0,
      BR_EQ      = 3'd1,
      BR_NE      = 3'd2,
      BR_LT      = 3'd3,
      BR_GE      = 3'd4,
      BR_LTU     = 3'd5,
      BR_GEU     = 3'd6
   } br_op_e;

   // Operand selectors
   typedef enum logic {OPR1_REG = 1'b0, OPR1_PC = 1'b1} opr1_sel_e;
   typedef enum logic {OPR2_REG = 1'b0, OPR2_IMM = 1'b1} opr2_sel_e;
   typedef enum logic {CMP_OPR2_REG = 1'b0, CMP_OPR2_IMM = 1'b1} cmp_opr2_sel_e;

endpackage : exe_ops_pkg

/* logic/exe_result_reg.sv */
// Result selection, redirect decision and the EXE/MEM pipeline register
`timescale 1ns/1ns

module exe_result_reg import exe_ops_pkg::*; #(
   parameter int XLEN,
   parameter int RF_AWIDTH
) (
   input  logic                 clk,
   input  logic                 reset_i,
   input  logic                 valid_i,
   input  logic [XLEN-1:0]      alu_result_i,
   input  logic [XLEN-1:0]      mul_result_i,
   input  mul_op_e              mul_op_i,
   input  logic [XLEN-1:0]      store_data_i,
   input  logic                 branch_taken_i,
   input  logic                 jump_req_i,
   input  logic                 branch_req_i,
   input  logic                 rd_wr_req_i,
   input  logic [RF_AWIDTH-1:0] rd_addr_i,
   output logic                 valid_o,
   output logic [XLEN-1:0]      result_o,
   output logic [XLEN-1:0]      store_data_o,
   output logic [RF_AWIDTH-1:0] rd_addr_o,
   output logic                 rd_wr_req_o,
   output logic                 new_pc_req_o,
   output logic [XLEN-1:0]      pc_new_o
);

   logic [XLEN-1:0] result_sel;
   logic            redirect;

   assign result_sel = (mul_op_i != MUL_NONE) ? mul_result_i : alu_result_i;
   assign redirect   = jump_req_i | (branch_req_i & branch_taken_i);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         valid_o      <= 1'b0;
         rd_wr_req_o  <= 1'b0;
         new_pc_req_o <= 1'b0;
         result_o     <= '0;
         store_data_o <= '0;
         rd_addr_o    <= '0;
         pc_new_o     <= '0;
      end else begin
         valid_o      <= valid_i;
         rd_wr_req_o  <= valid_i & rd_wr_req_i;
         new_pc_req_o <= valid_i & redirect;
         // Payload only moves with a real instruction
         if (valid_i) begin
            result_o     <= result_sel;
            store_data_o <= store_data_i;
            rd_addr_o    <= rd_addr_i;
            pc_new_o     <= {alu_result_i[XLEN-1:2], 2'b00};
         end
      end
   end

endmodule : exe_result_reg

/* logic/exe_stage.sv */
// Integer execute stage top with operand forwarding, ALU, compare, multiply and EXE/MEM register
`timescale 1ns/1ns

module exe_stage import exe_cfg_pkg::*, exe_ops_pkg::*; #(
   parameter int XLEN      = XLEN_DEFAULT,
   parameter int RF_AWIDTH = RF_AWIDTH_DEFAULT
) (
   input  logic                 clk,
   input  logic                 reset_i,
   input  logic                 valid_i,
   input  alu_op_e              alu_op_i,
   input  mul_op_e              mul_op_i,
   input  br_op_e               br_op_i,
   input  opr1_sel_e            opr1_sel_i,
   input  opr2_sel_e            opr2_sel_i,
   input  cmp_opr2_sel_e        cmp_opr2_sel_i,
   input  logic                 jump_req_i,
   input  logic                 branch_req_i,
   input  logic                 rd_wr_req_i,
   input  logic [RF_AWIDTH-1:0] rd_addr_i,
   input  logic [XLEN-1:0]      pc_i,
   input  logic [XLEN-1:0]      imm_i,
   input  logic [XLEN-1:0]      rs1_data_i,
   input  logic [XLEN-1:0]      rs2_data_i,
   input  logic                 fwd_lsu_rs1_i,
   input  logic                 fwd_wrb_rs1_i,
   input  logic                 fwd_lsu_rs2_i,
   input  logic                 fwd_wrb_rs2_i,
   input  logic [XLEN-1:0]      lsu_fb_data_i,
   input  logic [XLEN-1:0]      wrb_fb_data_i,
   output logic                 valid_o,
   output logic                 rd_wr_req_o,
   output logic                 new_pc_req_o,
   output logic [XLEN-1:0]      result_o,
   output logic [XLEN-1:0]      store_data_o,
   output logic [XLEN-1:0]      pc_new_o,
   output logic [RF_AWIDTH-1:0] rd_addr_o
);

   logic [XLEN-1:0] rs1_val;
   logic [XLEN-1:0] rs2_val;
   logic [XLEN-1:0] opr1;
   logic [XLEN-1:0] opr2;
   logic            lt;
   logic            ltu;
   logic            branch_taken;
   logic [XLEN-1:0] alu_result;
   logic [XLEN-1:0] mul_result;

   ////////////////////
   // Operands
   ////////////////////

   operand_select #(.XLEN(XLEN)) u_operand_select (
      .fwd_lsu_rs1_i (fwd_lsu_rs1_i),
      .fwd_wrb_rs1_i (fwd_wrb_rs1_i),
      .fwd_lsu_rs2_i (fwd_lsu_rs2_i),
      .fwd_wrb_rs2_i (fwd_wrb_rs2_i),
      .lsu_fb_data_i (lsu_fb_data_i),
      .wrb_fb_data_i (wrb_fb_data_i),
      .rs1_data_i    (rs1_data_i),
      .rs2_data_i    (rs2_data_i),
      .pc_i          (pc_i),
      .imm_i         (imm_i),
      .opr1_sel_i    (opr1_sel_i),
      .opr2_sel_i    (opr2_sel_i),
      .rs1_val_o     (rs1_val),
      .rs2_val_o     (rs2_val),
      .opr1_o        (opr1),
      .opr2_o        (opr2)
   );

   ////////////////////
   // Compute
   ////////////////////

   compare_unit #(.XLEN(XLEN)) u_compare_unit (
      .rs1_val_i      (rs1_val),
      .rs2_val_i      (rs2_val),
      .imm_i          (imm_i),
      .cmp_opr2_sel_i (cmp_opr2_sel_i),
      .br_op_i        (br_op_i),
      .lt_o           (lt),
      .ltu_o          (ltu),
      .branch_taken_o (branch_taken)
   );

   int_alu #(.XLEN(XLEN)) u_int_alu (
      .opr1_i       (opr1),
      .opr2_i       (opr2),
      .alu_op_i     (alu_op_i),
      .lt_i         (lt),
      .ltu_i        (ltu),
      .alu_result_o (alu_result)
   );

   mul_unit #(.XLEN(XLEN)) u_mul_unit (
      .opr1_i       (opr1),
      .opr2_i       (opr2),
      .mul_op_i     (mul_op_i),
      .mul_result_o (mul_result)
   );

   ////////////////////
   // EXE/MEM register
   ////////////////////

   // Forwarded rs2 becomes the store data
   exe_result_reg #(.XLEN(XLEN), .RF_AWIDTH(RF_AWIDTH)) u_exe_result_reg (
      .clk            (clk),
      .reset_i        (reset_i),
      .valid_i        (valid_i),
      .alu_result_i   (alu_result),
      .mul_result_i   (mul_result),
      .mul_op_i       (mul_op_i),
      .store_data_i   (rs2_val),
      .branch_taken_i (branch_taken),
      .jump_req_i     (jump_req_i),
      .branch_req_i   (branch_req_i),
      .rd_wr_req_i    (rd_wr_req_i),
      .rd_addr_i      (rd_addr_i),
      .valid_o        (valid_o),
      .result_o       (result_o),
      .store_data_o   (store_data_o),
      .rd_addr_o      (rd_addr_o),
      .rd_wr_req_o    (rd_wr_req_o),
      .new_pc_req_o   (new_pc_req_o),
      .pc_new_o       (pc_new_o)
   );

endmodule : exe_stage

/* logic/int_alu.sv */
// Base integer ALU covering logic, add/sub, shifts, copies and set-less-than
`timescale 1ns/1ns

module int_alu import exe_ops_pkg::*; #(
   parameter int XLEN
) (
   input  logic [XLEN-1:0] opr1_i,
   input  logic [XLEN-1:0] opr2_i,
   input  alu_op_e         alu_op_i,
   input  logic            lt_i,
   input  logic            ltu_i,
   output logic [XLEN-1:0] alu_result_o
);

   localparam int SHAMT_W = $clog2(XLEN);

   logic                do_sub;
   logic [XLEN-1:0]     adder_opr2;
   logic [XLEN-1:0]     adder_out;
   logic [SHAMT_W-1:0]  shamt;

   ////////////////////
   // Shared adder
   ////////////////////

   // Subtract as opr1 + ~opr2 + 1
   assign do_sub     = (alu_op_i == ALU_SUB);
   assign adder_opr2 = opr2_i ^ {XLEN{do_sub}};
   assign adder_out  = opr1_i + adder_opr2 + XLEN'(do_sub);

   assign shamt = opr2_i[SHAMT_W-1:0];

   ////////////////////
   // Result mux
   ////////////////////

   always_comb begin
      case (alu_op_i)
         ALU_AND:       alu_result_o = opr1_i & opr2_i;
         ALU_OR:        alu_result_o = opr1_i | opr2_i;
         ALU_XOR:       alu_result_o = opr1_i ^ opr2_i;
         ALU_ADD,
         ALU_SUB:       alu_result_o = adder_out;
         ALU_SLL:       alu_result_o = opr1_i << shamt;
         ALU_SRL:       alu_result_o = opr1_i >> shamt;
         ALU_SRA:       alu_result_o = $signed(opr1_i) >>> shamt;
         ALU_COPY_OPR1: alu_result_o = opr1_i;
         // LUI passes the immediate straight through
         ALU_COPY_OPR2: alu_result_o = opr2_i;
         ALU_SLT:       alu_result_o = XLEN'(lt_i);
         ALU_SLTU:      alu_result_o = XLEN'(ltu_i);
         default:       alu_result_o = '0;
      endcase
   end

endmodule : int_alu

/* logic/mul_unit.sv */
// Single-cycle multiplier for MUL, MULH, MULHSU and MULHU
`timescale 1ns/1ns

module mul_unit import exe_ops_pkg::*; #(
   parameter int XLEN
) (
   input  logic [XLEN-1:0] opr1_i,
   input  logic [XLEN-1:0] opr2_i,
   input  mul_op_e         mul_op_i,
   output logic [XLEN-1:0] mul_result_o
);

   logic                   opr1_signed;
   logic                   opr2_signed;
   logic signed [XLEN:0]   mul_opr1;
   logic signed [XLEN:0]   mul_opr2;
   logic signed [2*XLEN+1:0] product;

   // MULH treats both as signed, MULHSU only operand 1
   assign opr1_signed = (mul_op_i == MULH) || (mul_op_i == MULHSU);
   assign opr2_signed = (mul_op_i == MULH);

   // One extra bit makes every mix a signed multiply
   assign mul_opr1 = $signed({opr1_signed & opr1_i[XLEN-1], opr1_i});
   assign mul_opr2 = $signed({opr2_signed & opr2_i[XLEN-1], opr2_i});
   assign product  = mul_opr1 * mul_opr2;

   assign mul_result_o = (mul_op_i == MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];

endmodule : mul_unit

/* logic/operand_select.sv */
// Operand forwarding muxes and ALU operand selection for the execute stage
`timescale 1ns/1ns

module operand_select import exe_ops_pkg::*; #(
   parameter int XLEN
) (
   input  logic            fwd_lsu_rs1_i,
   input  logic            fwd_wrb_rs1_i,
   input  logic            fwd_lsu_rs2_i,
   input  logic            fwd_wrb_rs2_i,
   input  logic [XLEN-1:0] lsu_fb_data_i,
   input  logic [XLEN-1:0] wrb_fb_data_i,
   input  logic [XLEN-1:0] rs1_data_i,
   input  logic [XLEN-1:0] rs2_data_i,
   input  logic [XLEN-1:0] pc_i,
   input  logic [XLEN-1:0] imm_i,
   input  opr1_sel_e       opr1_sel_i,
   input  opr2_sel_e       opr2_sel_i,
   output logic [XLEN-1:0] rs1_val_o,
   output logic [XLEN-1:0] rs2_val_o,
   output logic [XLEN-1:0] opr1_o,
   output logic [XLEN-1:0] opr2_o
);

   // Memory stage data beats write-back data, which beats the register file
   function automatic logic [XLEN-1:0] fwd_pick(input logic            use_lsu,
                                                input logic            use_wrb,
                                                input logic [XLEN-1:0] lsu_data,
                                                input logic [XLEN-1:0] wrb_data,
                                                input logic [XLEN-1:0] rf_data);
      if (use_lsu) begin
         return lsu_data;
      end else if (use_wrb) begin
         return wrb_data;
      end
      return rf_data;
   endfunction

   assign rs1_val_o = fwd_pick(fwd_lsu_rs1_i, fwd_wrb_rs1_i, lsu_fb_data_i, wrb_fb_data_i,
                               rs1_data_i);
   assign rs2_val_o = fwd_pick(fwd_lsu_rs2_i, fwd_wrb_rs2_i, lsu_fb_data_i, wrb_fb_data_i,
                               rs2_data_i);

   // PC feeds AUIPC and jumps, immediate feeds I-type and address math
   assign opr1_o = (opr1_sel_i == OPR1_PC)  ? pc_i  : rs1_val_o;
   assign opr2_o = (opr2_sel_i == OPR2_IMM) ? imm_i : rs2_val_o;

endmodule : operand_select
